//--- all.f
+incdir+hw
hw/regFilePkg.sv
hw/lutDualPortRam.sv
hw/xorLiveValueTable.sv
hw/replicatedValueBanks.sv
hw/multiPortRegFile.sv
dv/multiPortRegFileTb.sv

//--- dv/multiPortRegFileTb.sv
// ------------------------------
// Multi-port register file testbench
// Directed and random writes and reads,
// every read port checked against a
// behavioral model each cycle
// ------------------------------

`include "regfile_defs.svh"

module multiPortRegFileTb;
    timeunit 1ns;
    timeprecision 1ps;

    import regFilePkg::*;

    localparam int ResetCycles    = 10;
    localparam int DirectedCycles = 100;
    localparam int RandomCycles   = 2000;
    localparam int MarginCycles   = 100;
    localparam int ClockPeriodNs  = 40;
    localparam int TimeoutNs      =
        (ResetCycles + DirectedCycles + RandomCycles + MarginCycles) * ClockPeriodNs;

    logic         clk = 1'b0;
    logic         reset;
    WriteReqArray writeReqs;
    ReadAddrArray readAddrs;
    ReadDataArray readData;

    // Inputs staged for the next rising edge
    WriteReqArray pendWrites;
    ReadAddrArray pendReads;

    // Expected contents start at zero like the RAMs
    RegData model [`RF_ENTRY_NUM];

    integer seed = 32'he35f;

    multiPortRegFile u_multiPortRegFile (
        .clk       (clk),
        .reset     (reset),
        .writeReqs (writeReqs),
        .readAddrs (readAddrs),
        .readData  (readData)
    );

    always #(ClockPeriodNs / 2) clk = ~clk;

    // Last write to an entry wins
    function automatic RegData expectedRead(input RegAddr addr);
        return model[addr];
    endfunction

    task automatic checkValue(input RegData actual, input RegData expected,
                              input int port, input string what);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: read port %0d, %s: got %h, expected %h",
                     $time, port, what, actual, expected);
            $display("Regression failed");
            $fatal(1, "Stopping on first read mismatch");
        end
    endtask

    function automatic void queueWrite(input int port, input RegAddr addr,
                                       input RegData data);
        pendWrites[port].enable = 1'b1;
        pendWrites[port].addr   = addr;
        pendWrites[port].data   = data;
    endfunction

    function automatic void readAll(input RegAddr addr);
        for (int r = 0; r < `RF_READ_NUM; r++) begin
            pendReads[r] = addr;
        end
    endfunction

    // True if an earlier port already writes this entry this cycle
    function automatic bit addrTaken(input RegAddr addr, input int upto);
        for (int q = 0; q < upto; q++) begin
            if (pendWrites[q].enable && pendWrites[q].addr == addr) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic stepCycle();
        @(posedge clk);
        writeReqs <= pendWrites;
        readAddrs <= pendReads;
        pendWrites = '0;
    endtask

    // Explicit check of all ports in the middle of the current cycle
    task automatic checkPorts(input RegData expected, input string what);
        @(negedge clk);
        for (int r = 0; r < `RF_READ_NUM; r++) begin
            checkValue(readData[r], expected, r, what);
        end
    endtask

    // Model follows the enabled writes at each edge
    always @(posedge clk) begin
        for (int p = 0; p < `RF_WRITE_NUM; p++) begin
            if (writeReqs[p].enable) begin
                model[writeReqs[p].addr] <= writeReqs[p].data;
            end
        end
    end

    // Compare every read port once per cycle on the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            for (int r = 0; r < `RF_READ_NUM; r++) begin
                checkValue(readData[r], expectedRead(readAddrs[r]), r, "model compare");
            end
        end
    end

    initial begin
        #(TimeoutNs);
        $display("Watchdog: the run timed out after %0d ns without finishing", TimeoutNs);
        $display("Regression failed");
        $fatal(1, "Timeout");
    end

    task automatic zeroAfterReset();
        for (int a = 0; a < `RF_ENTRY_NUM; a++) begin
            readAll(RegAddr'(a));
            stepCycle();
            checkPorts('0, "unwritten entry");
        end
    endtask

    task automatic writeEachPort();
        RegData data;
        for (int p = 0; p < `RF_WRITE_NUM; p++) begin
            data = RegData'(16'hA000 + p);
            queueWrite(p, RegAddr'(p + 1), data);
            readAll(RegAddr'(p + 1));
            stepCycle();
            checkPorts('0, "before write commits");
            stepCycle();
            checkPorts(data, "after single write");
        end
    endtask

    task automatic parallelWrites();
        queueWrite(0, RegAddr'(5), 16'h5a5a);
        queueWrite(1, RegAddr'(9), 16'h9c9c);
        stepCycle();
        readAll(RegAddr'(5));
        stepCycle();
        checkPorts(16'h5a5a, "port 0 in parallel write");
        readAll(RegAddr'(9));
        stepCycle();
        checkPorts(16'h9c9c, "port 1 in parallel write");
    endtask

    task automatic overwriteLiveValue();
        queueWrite(0, RegAddr'(12), 16'h1234);
        stepCycle();
        queueWrite(1, RegAddr'(12), 16'h4321);
        stepCycle();
        readAll(RegAddr'(12));
        stepCycle();
        checkPorts(16'h4321, "port 1 overwrite");
        queueWrite(0, RegAddr'(12), 16'hbeef);
        stepCycle();
        stepCycle();
        checkPorts(16'hbeef, "port 0 overwrite");
    endtask

    task automatic readDuringWrite();
        queueWrite(0, RegAddr'(20), 16'h1111);
        stepCycle();
        stepCycle();
        queueWrite(1, RegAddr'(20), 16'h2222);
        readAll(RegAddr'(20));
        stepCycle();
        checkPorts(16'h1111, "read during write");
        stepCycle();
        checkPorts(16'h2222, "cycle after write");
    endtask

    task automatic randomCycles(input int count);
        RegAddr addr;
        for (int c = 0; c < count; c++) begin
            for (int p = 0; p < `RF_WRITE_NUM; p++) begin
                if (($random(seed) & 1) != 0) begin
                    addr = RegAddr'($random(seed));
                    // Step to a free entry so ports never share one
                    while (addrTaken(addr, p)) begin
                        addr = addr + 1'b1;
                    end
                    queueWrite(p, addr, RegData'($random(seed)));
                end
            end
            for (int r = 0; r < `RF_READ_NUM; r++) begin
                pendReads[r] = RegAddr'($random(seed));
            end
            stepCycle();
        end
    endtask

    initial begin
        reset      = 1'b1;
        writeReqs  = '0;
        readAddrs  = '0;
        pendWrites = '0;
        pendReads  = '0;
        for (int a = 0; a < `RF_ENTRY_NUM; a++) begin
            model[a] = '0;
        end

        repeat (ResetCycles) @(posedge clk);
        reset <= 1'b0;

        zeroAfterReset();
        writeEachPort();
        parallelWrites();
        overwriteLiveValue();
        readDuringWrite();
        randomCycles(RandomCycles);

        // Let the last writes land and be read once
        stepCycle();
        stepCycle();
        @(posedge clk);

        $display("Regression passed");
        $finish;
    end

endmodule : multiPortRegFileTb

//--- hw/lutDualPortRam.sv
// ------------------------------
// LUT dual-port RAM
// One write port on the clock,
// one combinational read port
// ------------------------------

module lutDualPortRam #(
    parameter int EntryNum  = 32,
    parameter int DataWidth = 16
) (
    input  logic                        clk,
    input  logic                        writeEnable,
    input  logic [$clog2(EntryNum)-1:0] writeAddr,
    input  logic [DataWidth-1:0]        writeData,
    input  logic [$clog2(EntryNum)-1:0] readAddr,
    output logic [DataWidth-1:0]        readData
);

    // Storage, starts out all zero
    logic [DataWidth-1:0] mem [EntryNum] = '{default: '0};

    // Write commits at the edge
    always_ff @(posedge clk) begin
        if (writeEnable) begin
            mem[writeAddr] <= writeData;
        end
    end

    // Asynchronous read, so a same-cycle write is not seen yet
    always_comb begin
        readData = mem[readAddr];
    end

endmodule : lutDualPortRam

//--- hw/multiPortRegFile.sv
// ------------------------------
// Multi-port register file
// Live value table plus replicated
// LUT RAM banks, with combinational
// reads and clocked writes
// ------------------------------

`include "regfile_defs.svh"

module multiPortRegFile (
    input  logic                     clk,
    input  logic                     reset,
    input  regFilePkg::WriteReqArray writeReqs,
    input  regFilePkg::ReadAddrArray readAddrs,
    output regFilePkg::ReadDataArray readData
);
    import regFilePkg::*;

    // Last writer of each addressed entry, one per read port
    PortIndex [`RF_READ_NUM-1:0] liveValues;

    xorLiveValueTable u_xorLiveValueTable (
        .clk        (clk),
        .reset      (reset),
        .writeReqs  (writeReqs),
        .readAddrs  (readAddrs),
        .liveValues (liveValues)
    );

    replicatedValueBanks u_replicatedValueBanks (
        .clk        (clk),
        .reset      (reset),
        .writeReqs  (writeReqs),
        .readAddrs  (readAddrs),
        .liveValues (liveValues),
        .readData   (readData)
    );

endmodule : multiPortRegFile

//--- hw/regFilePkg.sv
// ------------------------------
// Register file types
// Address, data and live value
// types plus the per-port request
// and response arrays
// ------------------------------

`include "regfile_defs.svh"

package regFilePkg;

    // Entry index
    typedef logic [$clog2(`RF_ENTRY_NUM)-1:0] RegAddr;

    // One data word
    typedef logic [`RF_DATA_WIDTH-1:0] RegData;

    // Number of a write port, also the live value of an entry
    typedef logic [$clog2(`RF_WRITE_NUM)-1:0] PortIndex;

    // Request of a single write port
    typedef struct packed {
        logic   enable;
        RegAddr addr;
        RegData data;
    } WriteReq;

    // All write requests of one cycle
    typedef WriteReq [`RF_WRITE_NUM-1:0] WriteReqArray;

    // Read addresses, one per read port
    typedef RegAddr [`RF_READ_NUM-1:0] ReadAddrArray;

    // Read results, one per read port
    typedef RegData [`RF_READ_NUM-1:0] ReadDataArray;

endpackage : regFilePkg

//--- hw/regfile_defs.svh
// ------------------------------
// Register file configuration
// Entry count, word width and the
// number of read and write ports
// ------------------------------

`ifndef REGFILE_DEFS_SVH
`define REGFILE_DEFS_SVH

// Entries in the register file
`define RF_ENTRY_NUM 32

// Bits per entry
`define RF_DATA_WIDTH 16

// Combinational read ports
`define RF_READ_NUM 3

// Write ports, two or more for the live value table
`define RF_WRITE_NUM 2

`endif

//--- hw/replicatedValueBanks.sv
// ------------------------------
// Replicated value banks
// One LUT RAM per write port and
// read port. Each read port takes
// the bank named by its live value
// ------------------------------

`include "regfile_defs.svh"

module replicatedValueBanks (
    input  logic                                   clk,
    input  logic                                   reset,
    input  regFilePkg::WriteReqArray               writeReqs,
    input  regFilePkg::ReadAddrArray               readAddrs,
    input  regFilePkg::PortIndex [`RF_READ_NUM-1:0] liveValues,
    output regFilePkg::ReadDataArray               readData
);
    import regFilePkg::*;

    // bankData[j][r]: row of write port j, column of read port r
    RegData bankData [`RF_WRITE_NUM][`RF_READ_NUM];

    // Every bank in a row holds the same data, one copy per read port
    for (genvar j = 0; j < `RF_WRITE_NUM; j++) begin : gRow
        for (genvar r = 0; r < `RF_READ_NUM; r++) begin : gCol
            lutDualPortRam #(
                .EntryNum  (`RF_ENTRY_NUM),
                .DataWidth (`RF_DATA_WIDTH)
            ) u_bank (
                .clk         (clk),
                .writeEnable (writeReqs[j].enable),
                .writeAddr   (writeReqs[j].addr),
                .writeData   (writeReqs[j].data),
                .readAddr    (readAddrs[r]),
                .readData    (bankData[j][r])
            );
        end
    end

    // Pick the row of the port that wrote this entry last
    for (genvar r = 0; r < `RF_READ_NUM; r++) begin : gSelect
        assign readData[r] = bankData[liveValues[r]][r];
    end

    // The table must never name a write port that does not exist
    for (genvar r = 0; r < `RF_READ_NUM; r++) begin : gLiveCheck
        liveValueInRange : assert property (
            @(posedge clk) disable iff (reset)
            liveValues[r] < `RF_WRITE_NUM
        ) else $error("Read port %0d got live value %0d, only %0d write ports",
                      r, liveValues[r], `RF_WRITE_NUM);
    end

endmodule : replicatedValueBanks

//--- hw/xorLiveValueTable.sv
// ------------------------------
// XOR live value table
// Remembers per entry which write
// port wrote it last. Built from
// LUT RAM banks whose contents are
// XORed together on read
// ------------------------------

`include "regfile_defs.svh"

module xorLiveValueTable (
    input  logic                                   clk,
    input  logic                                   reset,
    input  regFilePkg::WriteReqArray               writeReqs,
    input  regFilePkg::ReadAddrArray               readAddrs,
    output regFilePkg::PortIndex [`RF_READ_NUM-1:0] liveValues
);
    import regFilePkg::*;

    // Word each write port puts into its own row of banks
    PortIndex storeValue [`RF_WRITE_NUM];

    // wBankData[j][i]: bank written by port j, read at port i's write address
    PortIndex wBankData [`RF_WRITE_NUM][`RF_WRITE_NUM];

    // rBankData[j][r]: bank written by port j, read by read port r
    PortIndex rBankData [`RF_WRITE_NUM][`RF_READ_NUM];

    // W-banks feed the write side of the other ports
    for (genvar j = 0; j < `RF_WRITE_NUM; j++) begin : gWriteRow
        for (genvar i = 0; i < `RF_WRITE_NUM; i++) begin : gWriteCol
            if (j != i) begin : gBank
                lutDualPortRam #(
                    .EntryNum  (`RF_ENTRY_NUM),
                    .DataWidth ($bits(PortIndex))
                ) u_wBank (
                    .clk         (clk),
                    .writeEnable (writeReqs[j].enable),
                    .writeAddr   (writeReqs[j].addr),
                    .writeData   (storeValue[j]),
                    .readAddr    (writeReqs[i].addr),
                    .readData    (wBankData[j][i])
                );
            end else begin : gNoBank
                // A port never reads back its own row
                assign wBankData[j][i] = '0;
            end
        end
    end

    // R-banks feed the read ports
    for (genvar j = 0; j < `RF_WRITE_NUM; j++) begin : gReadRow
        for (genvar r = 0; r < `RF_READ_NUM; r++) begin : gReadCol
            lutDualPortRam #(
                .EntryNum  (`RF_ENTRY_NUM),
                .DataWidth ($bits(PortIndex))
            ) u_rBank (
                .clk         (clk),
                .writeEnable (writeReqs[j].enable),
                .writeAddr   (writeReqs[j].addr),
                .writeData   (storeValue[j]),
                .readAddr    (readAddrs[r]),
                .readData    (rBankData[j][r])
            );
        end
    end

    // Store own index XOR the other rows, so the XOR of every row
    // at that entry gives back this port's index
    always_comb begin
        for (int i = 0; i < `RF_WRITE_NUM; i++) begin
            storeValue[i] = PortIndex'(i);
            for (int j = 0; j < `RF_WRITE_NUM; j++) begin
                storeValue[i] ^= wBankData[j][i];
            end
        end
    end

    // Recover the last writer for each read port
    always_comb begin
        for (int r = 0; r < `RF_READ_NUM; r++) begin
            liveValues[r] = '0;
            for (int j = 0; j < `RF_WRITE_NUM; j++) begin
                liveValues[r] ^= rBankData[j][r];
            end
        end
    end

    // Two writes to one entry would corrupt both the table and the value banks
    for (genvar i = 0; i < `RF_WRITE_NUM; i++) begin : gConflict
        for (genvar j = i + 1; j < `RF_WRITE_NUM; j++) begin : gPair
            noSameEntryWrite : assert property (
                @(posedge clk) disable iff (reset)
                !(writeReqs[i].enable && writeReqs[j].enable &&
                  writeReqs[i].addr == writeReqs[j].addr)
            ) else $error("Write ports %0d and %0d hit entry %0d in one cycle",
                          i, j, writeReqs[i].addr);
        end
    end

endmodule : xorLiveValueTable
